/* src/enigma_cfg.svh */
// Alphabet size, character width and ASCII base letter
`ifndef ENIGMA_CFG_SVH
`define ENIGMA_CFG_SVH

// Letters per alphabet, also the number of rotor positions
`define ALPHABET_SIZE 26

// Width of an ASCII character port
`define CHAR_WIDTH 8

// ASCII code of letter index 0
`define LETTER_BASE 8'h41

`endif

/* src/enigmaPkg.sv */
// Letter and position types, wiring table type, rotor, reflector and plugboard tables
`include "enigma_cfg.svh"

package enigmaPkg;

    typedef logic [4:0] letterT;
    typedef logic [4:0] positionT;

    // Entry i is the contact that input contact i connects to
    typedef letterT wiringT [0:`ALPHABET_SIZE-1];

    localparam wiringT ROTOR1_WIRING = '{
        5'd7,  5'd12, 5'd21, 5'd17, 5'd0,  5'd2,  5'd22, 5'd20, 5'd23,
        5'd18, 5'd9,  5'd25, 5'd15, 5'd3,  5'd14, 5'd13, 5'd11, 5'd8,
        5'd4,  5'd10, 5'd6,  5'd5,  5'd19, 5'd16, 5'd24, 5'd1
    };

    localparam wiringT ROTOR2_WIRING = '{
        5'd19, 5'd4,  5'd7,  5'd6,  5'd12, 5'd17, 5'd8,  5'd5,  5'd2,
        5'd0,  5'd1,  5'd20, 5'd25, 5'd9,  5'd14, 5'd22, 5'd24, 5'd18,
        5'd15, 5'd13, 5'd3,  5'd10, 5'd21, 5'd16, 5'd11, 5'd23
    };

    localparam wiringT ROTOR3_WIRING = '{
        5'd19, 5'd0,  5'd6,  5'd1,  5'd15, 5'd2,  5'd18, 5'd3,  5'd16,
        5'd4,  5'd20, 5'd5,  5'd21, 5'd13, 5'd25, 5'd7,  5'd24, 5'd8,
        5'd23, 5'd9,  5'd22, 5'd11, 5'd17, 5'd10, 5'd14, 5'd12
    };

    // Involution with no letter mapped to itself
    localparam wiringT REFLECTOR_WIRING = '{
        5'd24, 5'd17, 5'd20, 5'd7,  5'd16, 5'd18, 5'd11, 5'd3,  5'd15,
        5'd23, 5'd13, 5'd6,  5'd14, 5'd10, 5'd12, 5'd8,  5'd4,  5'd1,
        5'd5,  5'd25, 5'd2,  5'd22, 5'd21, 5'd9,  5'd0,  5'd19
    };

    // Swaps A-E, B-K, C-M and F-G
    localparam wiringT PLUGBOARD_WIRING = '{
        5'd4,  5'd10, 5'd12, 5'd3,  5'd0,  5'd6,  5'd5,  5'd7,  5'd8,
        5'd9,  5'd1,  5'd11, 5'd2,  5'd13, 5'd14, 5'd15, 5'd16, 5'd17,
        5'd18, 5'd19, 5'd20, 5'd21, 5'd22, 5'd23, 5'd24, 5'd25
    };

endpackage

/* src/rotorWheel.sv */
// Single rotor forward and backward substitution at a given position
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module rotorWheel #(
    parameter enigmaPkg::wiringT WIRING = enigmaPkg::ROTOR1_WIRING
) (
    input  enigmaPkg::positionT position,
    input  enigmaPkg::letterT   forwardIn,
    input  enigmaPkg::letterT   backwardIn,
    output enigmaPkg::letterT   forwardOut,
    output enigmaPkg::letterT   backwardOut
);

    // Inverse wiring for the return path
    function automatic enigmaPkg::wiringT invertWiring(input enigmaPkg::wiringT wiring);
        enigmaPkg::wiringT inverse;
        for (int i = 0; i < `ALPHABET_SIZE; i++) begin
            inverse[wiring[i]] = 5'(i);
        end
        return inverse;
    endfunction

    function automatic enigmaPkg::letterT addMod(
        input enigmaPkg::letterT   value,
        input enigmaPkg::positionT offset
    );
        logic [5:0] sum;
        sum = 6'(value) + 6'(offset);
        if (sum >= 6'(`ALPHABET_SIZE)) begin
            sum = sum - 6'(`ALPHABET_SIZE);
        end
        return sum[4:0];
    endfunction

    function automatic enigmaPkg::letterT subMod(
        input enigmaPkg::letterT   value,
        input enigmaPkg::positionT offset
    );
        logic [5:0] diff;
        diff = 6'(value) + 6'(`ALPHABET_SIZE) - 6'(offset);
        if (diff >= 6'(`ALPHABET_SIZE)) begin
            diff = diff - 6'(`ALPHABET_SIZE);
        end
        return diff[4:0];
    endfunction

    localparam enigmaPkg::wiringT INVERSE = invertWiring(WIRING);

    enigmaPkg::letterT forwardContact;
    enigmaPkg::letterT backwardContact;

    // Rotate into the rotor frame, substitute, rotate back out
    assign forwardContact  = addMod(forwardIn, position);
    assign forwardOut      = subMod(WIRING[forwardContact], position);

    assign backwardContact = addMod(backwardIn, position);
    assign backwardOut     = subMod(INVERSE[backwardContact], position);

endmodule

/* src/rotorStepper.sv */
// Letter filter, start position load, odometer stepping and stage-one register
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module rotorStepper (
    input  logic                   load,
    input  logic                   reset,
    input  logic [`CHAR_WIDTH-1:0] charIn,
    input  logic                   charValid,
    input  logic                   setPositions,
    input  enigmaPkg::positionT    startPosition1,
    input  enigmaPkg::positionT    startPosition2,
    input  enigmaPkg::positionT    startPosition3,
    output enigmaPkg::letterT      letter,
    output logic                   letterValid,
    output enigmaPkg::positionT    position1,
    output enigmaPkg::positionT    position2,
    output enigmaPkg::positionT    position3
);

    localparam enigmaPkg::positionT LAST_POSITION = 5'(`ALPHABET_SIZE - 1);

    function automatic enigmaPkg::positionT advance(input enigmaPkg::positionT current);
        return (current == LAST_POSITION) ? '0 : current + 1'b1;
    endfunction

    logic [`CHAR_WIDTH-1:0] charOffset;
    logic                   isLetter;
    logic                   accept;
    logic                   wrap1;
    logic                   wrap2;
    enigmaPkg::positionT    nextPosition1;
    enigmaPkg::positionT    nextPosition2;
    enigmaPkg::positionT    nextPosition3;

    assign charOffset = charIn - `LETTER_BASE;
    assign isLetter   = (charIn >= `LETTER_BASE) && (charIn < `LETTER_BASE + `ALPHABET_SIZE);

    // Position load beats a letter in the same cycle
    assign accept = charValid && isLetter && !setPositions;

    // Odometer carry chain
    assign wrap1         = (position1 == LAST_POSITION);
    assign wrap2         = wrap1 && (position2 == LAST_POSITION);
    assign nextPosition1 = advance(position1);
    assign nextPosition2 = wrap1 ? advance(position2) : position2;
    assign nextPosition3 = wrap2 ? advance(position3) : position3;

    always_ff @(posedge load) begin
        if (reset) begin
            letterValid <= 1'b0;
            position1   <= '0;
            position2   <= '0;
            position3   <= '0;
        end else begin
            letterValid <= accept;
            if (setPositions) begin
                position1 <= startPosition1;
                position2 <= startPosition2;
                position3 <= startPosition3;
            end else if (accept) begin
                position1 <= nextPosition1;
                position2 <= nextPosition2;
                position3 <= nextPosition3;
            end
        end
    end

    always_ff @(posedge load) begin
        if (accept) begin
            letter <= charOffset[4:0];
        end
    end

    positionRange: assert property (@(posedge load) disable iff (reset)
        position1 < `ALPHABET_SIZE && position2 < `ALPHABET_SIZE
        && position3 < `ALPHABET_SIZE);

    // A character outside A to Z arriving alone leaves no trace downstream
    nonLetterDropped: assert property (@(posedge load) disable iff (reset)
        charValid && !setPositions
        && !(charIn inside {[`LETTER_BASE:`LETTER_BASE + `ALPHABET_SIZE - 1]})
        |=> !letterValid && $stable(position1) && $stable(position2)
        && $stable(position3));

endmodule

/* src/scrambler.sv */
// Plugboard, three rotors, reflector, return path and output register
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module scrambler (
    input  logic                   load,
    input  logic                   reset,
    input  enigmaPkg::letterT      letter,
    input  logic                   letterValid,
    input  enigmaPkg::positionT    position1,
    input  enigmaPkg::positionT    position2,
    input  enigmaPkg::positionT    position3,
    output logic [`CHAR_WIDTH-1:0] cipherChar,
    output logic                   cipherValid
);

    enigmaPkg::letterT plugForward;
    enigmaPkg::letterT rotor1ToRotor2;
    enigmaPkg::letterT rotor2ToRotor3;
    enigmaPkg::letterT rotor3ToReflector;
    enigmaPkg::letterT reflectorToRotor3;
    enigmaPkg::letterT rotor3ToRotor2;
    enigmaPkg::letterT rotor2ToRotor1;
    enigmaPkg::letterT rotor1ToPlug;
    enigmaPkg::letterT cipherLetter;

    assign plugForward = enigmaPkg::PLUGBOARD_WIRING[letter];

    // Fast rotor sits next to the plugboard
    rotorWheel #(
        .WIRING(enigmaPkg::ROTOR1_WIRING)
    ) rotor1 (
        .position   (position1),
        .forwardIn  (plugForward),
        .backwardIn (rotor2ToRotor1),
        .forwardOut (rotor1ToRotor2),
        .backwardOut(rotor1ToPlug)
    );

    rotorWheel #(
        .WIRING(enigmaPkg::ROTOR2_WIRING)
    ) rotor2 (
        .position   (position2),
        .forwardIn  (rotor1ToRotor2),
        .backwardIn (rotor3ToRotor2),
        .forwardOut (rotor2ToRotor3),
        .backwardOut(rotor2ToRotor1)
    );

    rotorWheel #(
        .WIRING(enigmaPkg::ROTOR3_WIRING)
    ) rotor3 (
        .position   (position3),
        .forwardIn  (rotor2ToRotor3),
        .backwardIn (reflectorToRotor3),
        .forwardOut (rotor3ToReflector),
        .backwardOut(rotor3ToRotor2)
    );

    // Turn around and go back through the plugboard
    assign reflectorToRotor3 = enigmaPkg::REFLECTOR_WIRING[rotor3ToReflector];
    assign cipherLetter      = enigmaPkg::PLUGBOARD_WIRING[rotor1ToPlug];

    always_ff @(posedge load) begin
        if (reset) begin
            cipherValid <= 1'b0;
        end else begin
            cipherValid <= letterValid;
        end
    end

    always_ff @(posedge load) begin
        if (letterValid) begin
            cipherChar <= `LETTER_BASE + `CHAR_WIDTH'(cipherLetter);
        end
    end

    // Reflector has no fixed point, so no letter enciphers to itself
    noSelfCipher: assert property (@(posedge load) disable iff (reset)
        letterValid |=> cipherChar != `LETTER_BASE + `CHAR_WIDTH'($past(letter)));

endmodule

/* src/enigmaTop.sv */
// Top level joining the rotor stepper and the scrambler
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module enigmaTop (
    input  logic                   load,
    input  logic                   reset,
    input  logic [`CHAR_WIDTH-1:0] charIn,
    input  logic                   charValid,
    input  logic                   setPositions,
    input  enigmaPkg::positionT    startPosition1,
    input  enigmaPkg::positionT    startPosition2,
    input  enigmaPkg::positionT    startPosition3,
    output logic [`CHAR_WIDTH-1:0] cipherChar,
    output logic                   cipherValid
);

    enigmaPkg::letterT   letter;
    logic                letterValid;
    enigmaPkg::positionT position1;
    enigmaPkg::positionT position2;
    enigmaPkg::positionT position3;

    // Stage one filters letters and steps the rotors
    rotorStepper stepper (
        .load          (load),
        .reset         (reset),
        .charIn        (charIn),
        .charValid     (charValid),
        .setPositions  (setPositions),
        .startPosition1(startPosition1),
        .startPosition2(startPosition2),
        .startPosition3(startPosition3),
        .letter        (letter),
        .letterValid   (letterValid),
        .position1     (position1),
        .position2     (position2),
        .position3     (position3)
    );

    // Stage two enciphers
    scrambler scrambleStage (
        .load       (load),
        .reset      (reset),
        .letter     (letter),
        .letterValid(letterValid),
        .position1  (position1),
        .position2  (position2),
        .position3  (position3),
        .cipherChar (cipherChar),
        .cipherValid(cipherValid)
    );

endmodule

/* verification/enigmaChecker.sv */
// Reference cipher model, expected-value queue, output comparison and error counts
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module enigmaChecker (
    input  logic                   load,
    input  logic                   reset,
    input  logic [`CHAR_WIDTH-1:0] charIn,
    input  logic                   charValid,
    input  logic                   setPositions,
    input  enigmaPkg::positionT    startPosition1,
    input  enigmaPkg::positionT    startPosition2,
    input  enigmaPkg::positionT    startPosition3,
    input  logic [`CHAR_WIDTH-1:0] cipherChar,
    input  logic                   cipherValid,
    input  logic                   recordActive,
    input  logic                   replayActive,
    input  logic                   endOfTest,
    output int                     mismatchCount,
    output int                     otherErrors
);

    localparam int N = `ALPHABET_SIZE;
    // Output seen two edges after the letter is sampled
    localparam int LATENCY   = 2;
    localparam int PLUGBOARD = 0;
    localparam int REFLECTOR = 4;

    int         pos1;
    int         pos2;
    int         pos3;
    int         cycle;
    bit         finalDone;
    logic [7:0] expectedQ[$];
    logic [7:0] plainQ[$];
    int         issuedQ[$];
    bit         roundTripQ[$];
    logic [7:0] plainLog[$];

    function automatic int tableEntry(input int which, input int idx);
        case (which)
            1:       return enigmaPkg::ROTOR1_WIRING[idx];
            2:       return enigmaPkg::ROTOR2_WIRING[idx];
            3:       return enigmaPkg::ROTOR3_WIRING[idx];
            4:       return enigmaPkg::REFLECTOR_WIRING[idx];
            default: return enigmaPkg::PLUGBOARD_WIRING[idx];
        endcase
    endfunction

    function automatic int forwardStep(input int which, input int x, input int p);
        return (tableEntry(which, (x + p) % N) - p + N) % N;
    endfunction

    // Inverse found by searching the table for the contact
    function automatic int backwardStep(input int which, input int x, input int p);
        int contact;
        int source;
        contact = (x + p) % N;
        source  = 0;
        for (int j = 0; j < N; j++) begin
            if (tableEntry(which, j) == contact) begin
                source = j;
            end
        end
        return (source - p + N) % N;
    endfunction

    function automatic logic [7:0] encipher(input int plain, input int p1, p2, p3);
        int x;
        x = tableEntry(PLUGBOARD, plain);
        x = forwardStep(1, x, p1);
        x = forwardStep(2, x, p2);
        x = forwardStep(3, x, p3);
        x = tableEntry(REFLECTOR, x);
        x = backwardStep(3, x, p3);
        x = backwardStep(2, x, p2);
        x = backwardStep(1, x, p1);
        x = tableEntry(PLUGBOARD, x);
        return `LETTER_BASE + 8'(x);
    endfunction

    always @(posedge load) begin
        logic [7:0] expected;
        logic [7:0] plainChar;
        logic [7:0] original;
        int         index;
        cycle++;
        index = int'(charIn) - int'(`LETTER_BASE);
        if (reset) begin
            pos1 = 0;
            pos2 = 0;
            pos3 = 0;
        end else begin
            if (cipherValid && expectedQ.size() == 0) begin
                $display("cipherValid at cycle %0d with no letter pending", cycle);
                otherErrors++;
            end else if (cipherValid) begin
                expected  = expectedQ.pop_front();
                plainChar = plainQ.pop_front();
                if (cipherChar !== expected) begin
                    $display("MISMATCH cipherChar expected %h actual %h", expected, cipherChar);
                    mismatchCount++;
                end
                if (cycle - issuedQ.pop_front() != LATENCY) begin
                    $display("Output at cycle %0d came after the wrong latency", cycle);
                    otherErrors++;
                end
                if (cipherChar == plainChar) begin
                    $display("Letter %h enciphered to itself at cycle %0d", plainChar, cycle);
                    otherErrors++;
                end
                if (roundTripQ.pop_front()) begin
                    original = (plainLog.size() > 0) ? plainLog.pop_front() : 8'h00;
                    if (cipherChar !== original) begin
                        $display("MISMATCH cipherChar expected %h actual %h in round trip",
                                 original, cipherChar);
                        mismatchCount++;
                    end
                end
            end
            if (setPositions) begin
                pos1 = startPosition1;
                pos2 = startPosition2;
                pos3 = startPosition3;
            end else if (charValid && index >= 0 && index < N) begin
                // Odometer where each wheel moves when the one before it wraps to 0
                pos1 = (pos1 + 1) % N;
                if (pos1 == 0) begin
                    pos2 = (pos2 + 1) % N;
                    if (pos2 == 0) begin
                        pos3 = (pos3 + 1) % N;
                    end
                end
                if (recordActive) begin
                    plainLog.push_back(charIn);
                end
                expectedQ.push_back(encipher(index, pos1, pos2, pos3));
                plainQ.push_back(charIn);
                issuedQ.push_back(cycle);
                roundTripQ.push_back(replayActive);
            end
            if (endOfTest && !finalDone) begin
                finalDone = 1'b1;
                if (expectedQ.size() != 0) begin
                    $display("%0d letters never produced an output", expectedQ.size());
                    otherErrors++;
                end
                if (plainLog.size() != 0) begin
                    $display("%0d recorded letters never came back", plainLog.size());
                    otherErrors++;
                end
            end
        end
    end

endmodule

/* verification/tbEnigma.sv */
// Testbench top with clock, reset, LFSR stimulus, test sequence and watchdog
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module tbEnigma;

    localparam int LETTER_COUNT    = 700;
    localparam int MIXED_COUNT     = 60;
    localparam int TOTAL_CHARS     = 1 + LETTER_COUNT + MIXED_COUNT + LETTER_COUNT + 2;
    localparam int WATCHDOG_CYCLES = TOTAL_CHARS * 4 + 200;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                   load;
    logic                   reset;
    logic [`CHAR_WIDTH-1:0] charIn;
    logic                   charValid;
    logic                   setPositions;
    enigmaPkg::positionT    startPosition1;
    enigmaPkg::positionT    startPosition2;
    enigmaPkg::positionT    startPosition3;
    logic [`CHAR_WIDTH-1:0] cipherChar;
    logic                   cipherValid;
    logic                   recordActive;
    logic                   replayActive;
    logic                   endOfTest;
    int                     mismatchCount;
    int                     otherErrors;
    logic [31:0]            lfsrState;
    logic [7:0]             cipherLog[$];
    logic [7:0]             cipherText[$];

    enigmaTop uut (.*);
    enigmaChecker scoreboard (.*);

    initial begin
        load = 1'b0;
        forever #5 load = ~load;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic randomLetter(output logic [7:0] c);
        logic [31:0] bits;
        takeBits(5, bits);
        c = `LETTER_BASE + 8'(bits % `ALPHABET_SIZE);
    endtask

    task automatic randomPosition(output enigmaPkg::positionT p);
        logic [31:0] bits;
        takeBits(5, bits);
        p = 5'(bits % `ALPHABET_SIZE);
    endtask

    task automatic driveChar(input logic [7:0] c, input logic withLoad);
        @(negedge load);
        charIn       = c;
        charValid    = 1'b1;
        setPositions = withLoad;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(negedge load);
            charValid    = 1'b0;
            setPositions = 1'b0;
        end
    endtask

    // Random idle cycle so that only some letters go back to back
    task automatic maybeGap();
        logic [31:0] bits;
        takeBits(1, bits);
        if (bits[0]) begin
            idleCycles(1);
        end
    endtask

    task automatic loadPositions(input enigmaPkg::positionT p1, p2, p3);
        @(negedge load);
        charValid      = 1'b0;
        setPositions   = 1'b1;
        startPosition1 = p1;
        startPosition2 = p2;
        startPosition3 = p3;
    endtask

    always @(posedge load) begin
        if (!reset && cipherValid) begin
            cipherLog.push_back(cipherChar);
        end
    end

    initial begin
        logic [31:0]         bits;
        logic [7:0]          c;
        enigmaPkg::positionT saved1;
        enigmaPkg::positionT saved2;
        enigmaPkg::positionT saved3;
        string               nonLetters;
        reset          = 1'b1;
        charIn         = '0;
        charValid      = 1'b0;
        setPositions   = 1'b0;
        startPosition1 = '0;
        startPosition2 = '0;
        startPosition3 = '0;
        recordActive   = 1'b0;
        replayActive   = 1'b0;
        endOfTest      = 1'b0;
        lfsrState      = 32'h0113_000d;
        nonLetters     = "0123456789 abcdefghijklmnopqrstuvwxyz@[`{";
        repeat (10) @(negedge load);
        reset = 1'b0;

        // First letter with all rotors at 0
        idleCycles(5);
        randomLetter(c);
        driveChar(c, 1'b0);
        idleCycles(4);

        // Long random run from random starts whose ciphertext is kept for the round trip
        randomPosition(saved1);
        randomPosition(saved2);
        randomPosition(saved3);
        loadPositions(saved1, saved2, saved3);
        cipherLog.delete();
        recordActive = 1'b1;
        for (int i = 0; i < LETTER_COUNT; i++) begin
            randomLetter(c);
            driveChar(c, 1'b0);
            maybeGap();
        end
        idleCycles(1);
        recordActive = 1'b0;
        idleCycles(4);
        cipherText = cipherLog;

        // Letters mixed with digits, lowercase, space and neighbours of A and Z
        for (int i = 0; i < MIXED_COUNT; i++) begin
            takeBits(1, bits);
            if (bits[0]) begin
                randomLetter(c);
            end else begin
                takeBits(6, bits);
                c = nonLetters[bits % nonLetters.len()];
            end
            driveChar(c, 1'b0);
            maybeGap();
        end
        idleCycles(4);

        // Ciphertext back through the machine from the same starts
        loadPositions(saved1, saved2, saved3);
        replayActive = 1'b1;
        for (int i = 0; i < cipherText.size(); i++) begin
            driveChar(cipherText[i], 1'b0);
            maybeGap();
        end
        idleCycles(1);
        replayActive = 1'b0;
        idleCycles(4);

        // Load and letter in one cycle where the load wins
        randomPosition(saved1);
        randomPosition(saved2);
        randomPosition(saved3);
        startPosition1 = saved1;
        startPosition2 = saved2;
        startPosition3 = saved3;
        randomLetter(c);
        driveChar(c, 1'b1);
        randomLetter(c);
        driveChar(c, 1'b0);
        idleCycles(4);

        endOfTest = 1'b1;
        idleCycles(2);
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge load);
        $display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+src
src/enigmaPkg.sv
src/rotorWheel.sv
src/rotorStepper.sv
src/scrambler.sv
src/enigmaTop.sv
verification/enigmaChecker.sv
verification/tbEnigma.sv

/* Bender.yml */
package:
  name: enigma

sources:
  - include_dirs:
      - src
    files:
      - src/enigmaPkg.sv
      - src/rotorWheel.sv
      - src/rotorStepper.sv
      - src/scrambler.sv
      - src/enigmaTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/enigmaChecker.sv
      - verification/tbEnigma.sv
